// ==== design/axi_read_shim.sv ====
/* Read-only AXI-style master with a single burst in flight. Read data is always accepted,
   so there is no R ready, and any non-OKAY beat marks the whole burst as failed. */
`timescale 1ns/100ps
`default_nettype none

module axi_read_shim import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rd_req_i,
  input  ar_chan_t    ar_i,
  input  logic        ar_ready_i,
  input  r_chan_t     r_i,
  input  logic        r_valid_i,
  output logic        rd_gnt_o,
  output ar_chan_t    ar_o,
  output logic        ar_valid_o,
  output logic        beat_valid_o,
  output logic [63:0] beat_data_o,
  output logic        beat_last_o,
  output logic        beat_err_o
);

  logic       open_q;
  logic [7:0] cnt_q;
  logic [7:0] len_q;
  logic [1:0] id_q;
  logic       err_q;
  logic       ar_hs;
  logic       beat_err;

  // No new address phase until the open burst has delivered its last beat
  assign ar_valid_o = rd_req_i & ~open_q;
  assign ar_o       = ar_i;
  assign ar_hs      = ar_valid_o & ar_ready_i;
  assign rd_gnt_o   = ar_hs;

  assign beat_valid_o = r_valid_i & open_q;
  assign beat_data_o  = r_i.data;
  assign beat_last_o  = r_i.last;
  assign beat_err     = (r_i.resp != 2'b00);
  assign beat_err_o   = err_q | beat_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q <= 1'b0;
      cnt_q  <= '0;
      len_q  <= '0;
      id_q   <= '0;
      err_q  <= 1'b0;
    end else if (ar_hs) begin
      open_q <= 1'b1;
      cnt_q  <= '0;
      len_q  <= ar_i.len;
      id_q   <= ar_i.id;
      err_q  <= 1'b0;
    end else if (beat_valid_o) begin
      cnt_q <= cnt_q + 8'd1;
      err_q <= beat_err_o;
      if (r_i.last) begin
        open_q <= 1'b0;
      end
    end
  end

  a_last_at_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_valid_o |-> (r_i.last == (cnt_q == len_q)) && (r_i.id == id_q));

endmodule

`default_nettype wire

// ==== design/fetch_ctrl.sv ====
/* Fetch front end with one miss in flight. A hit answers one cycle after acceptance and
   a miss answers one cycle after its refill. Non-cacheable words come back at offset 0. */
`timescale 1ns/100ps
`default_nettype none

`include "icache_cfg.svh"

module fetch_ctrl import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  fetch_req_t  fetch_req_i,
  input  logic        en_i,
  input  logic        flush_i,
  input  logic        hit_i,
  input  logic [63:0] hit_data_i,
  input  logic        refill_valid_i,
  input  refill_t     refill_i,
  output logic        fetch_ready_o,
  output fetch_rsp_t  fetch_rsp_o,
  output logic        lookup_o,
  output fetch_addr_u lookup_addr_o,
  output logic        miss_req_o,
  output miss_req_t   miss_o,
  output logic        miss_pulse_o
);

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WAIT_REFILL
  } state_e;

  state_e            state_d, state_q;
  fetch_addr_u       addr_q;
  fetch_addr_u       bus_addr;
  logic              nc_q;
  logic [1:0]        tid_q;
  logic              accept;
  logic              req_nc;
  logic              hit_rsp;
  logic              refill_take;
  logic [WOFF_W-1:0] word_sel;
  logic              rsp_vld_q;
  logic [63:0]       rsp_data_q;
  logic              rsp_err_q;

  // Bypass when the cache is off or the address is in the uncached region
  assign req_nc = ~en_i | (fetch_req_i.addr.paddr >= `ICACHE_UNCACHED_BASE);

  assign hit_rsp       = (state_q == LOOKUP) & hit_i;
  assign fetch_ready_o = ~flush_i & ((state_q == IDLE) | hit_rsp);
  assign accept        = fetch_req_i.req & fetch_ready_o;

  // Only cacheable fetches probe the array
  assign lookup_o      = accept & ~req_nc;
  assign lookup_addr_o = fetch_req_i.addr;

  // Bypassed fetches never hit, so they fall straight into the miss path
  assign miss_req_o   = (state_q == LOOKUP) & ~hit_i;
  assign miss_pulse_o = miss_req_o;

  // Line-aligned for a fill, word-aligned for a bypass
  always_comb begin
    bus_addr        = addr_q;
    bus_addr.f.boff = '0;
    if (!nc_q) begin
      bus_addr.f.woff = '0;
    end
  end

  assign miss_o = '{paddr: bus_addr.paddr, nc: nc_q, tid: tid_q};

  assign refill_take = (state_q == WAIT_REFILL) & refill_valid_i & (refill_i.tid == tid_q);
  assign word_sel    = nc_q ? '0 : addr_q.f.woff;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (!hit_i) begin
          state_d = WAIT_REFILL;
        end else if (!accept) begin
          state_d = IDLE;
        end
      end
      WAIT_REFILL: begin
        if (refill_take) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      nc_q      <= 1'b0;
      tid_q     <= '0;
      rsp_vld_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      rsp_vld_q <= refill_take;
      if (accept) begin
        nc_q <= req_nc;
      end
      if (refill_take) begin
        tid_q <= tid_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_req_i.addr;
    end
    if (refill_take) begin
      rsp_data_q <= refill_i.data[word_sel];
      rsp_err_q  <= refill_i.err;
    end
  end

  // Hit and refill responses never share a cycle
  assign fetch_rsp_o.valid = hit_rsp | rsp_vld_q;
  assign fetch_rsp_o.data  = hit_rsp ? hit_data_i : rsp_data_q;
  assign fetch_rsp_o.err   = ~hit_rsp & rsp_err_q;

  // Every refill has to find the controller waiting on the same id
  a_refill_while_waiting: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_valid_i |-> (state_q == WAIT_REFILL) && (refill_i.tid == tid_q));

endmodule

`default_nettype wire

// ==== design/icache_array.sv ====
/* Direct-mapped tag and line store with registered lookup. A fill goes to the set of the
   last lookup that missed, so only one fill may be pending at a time. */
`timescale 1ns/100ps
`default_nettype none

`include "icache_cfg.svh"

module icache_array import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        lookup_i,
  input  fetch_addr_u lookup_addr_i,
  input  logic        flush_i,
  input  logic        refill_valid_i,
  input  refill_t     refill_i,
  output logic        hit_o,
  output logic [63:0] hit_data_o
);

  logic [`ICACHE_SETS-1:0] valid_q;
  logic [TAG_W-1:0]        tag_q  [`ICACHE_SETS];
  line_t                   line_q [`ICACHE_SETS];
  fetch_addr_u             pend_addr_q;
  logic                    pend_nc_q;
  logic                    hit_d;
  logic                    fill_we;

  assign hit_d = valid_q[lookup_addr_i.f.idx] &
                 (tag_q[lookup_addr_i.f.idx] == lookup_addr_i.f.tag);

  // Bypass refills and errored bursts leave the array untouched
  assign fill_we = refill_valid_i & ~refill_i.err & ~pend_nc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      hit_o     <= 1'b0;
      pend_nc_q <= 1'b1;
    end else begin
      hit_o <= lookup_i & hit_d;
      // A hit expects no fill, a miss arms one
      if (lookup_i) begin
        pend_nc_q <= hit_d;
      end else if (refill_valid_i) begin
        pend_nc_q <= 1'b1;
      end
      if (fill_we) begin
        valid_q[pend_addr_q.f.idx] <= 1'b1;
      end
      // Flush wins over a fill in the same cycle
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      hit_data_o  <= line_q[lookup_addr_i.f.idx][lookup_addr_i.f.woff];
      pend_addr_q <= lookup_addr_i;
    end
    if (fill_we) begin
      tag_q[pend_addr_q.f.idx]  <= pend_addr_q.f.tag;
      line_q[pend_addr_q.f.idx] <= refill_i.data;
    end
  end

endmodule

`default_nettype wire

// ==== design/icache_pkg.sv ====
/* Shared types of the fetch cache. The field layout of fetch_addr_u follows the geometry
   in icache_cfg.svh, with 64-bit words and 8 bytes per word. */
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

  localparam int unsigned IDX_W  = $clog2(`ICACHE_SETS);
  localparam int unsigned WOFF_W = $clog2(`ICACHE_LINE_WORDS);
  localparam int unsigned TAG_W  = `ICACHE_PADDR_W - IDX_W - WOFF_W - 3;

  typedef logic [`ICACHE_LINE_WORDS-1:0][63:0] line_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  idx;
    logic [WOFF_W-1:0] woff;
    logic [2:0]        boff;
  } fetch_fields_t;

  // Same address word, seen raw by the bus side and split by the array
  typedef union packed {
    logic [`ICACHE_PADDR_W-1:0] paddr;
    fetch_fields_t              f;
  } fetch_addr_u;

  typedef struct packed {
    logic        req;
    fetch_addr_u addr;
  } fetch_req_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] data;
    logic        err;
  } fetch_rsp_t;

  typedef struct packed {
    logic [`ICACHE_PADDR_W-1:0] paddr;
    logic                       nc;
    logic [1:0]                 tid;
  } miss_req_t;

  typedef struct packed {
    line_t      data;
    logic       err;
    logic [1:0] tid;
  } refill_t;

  // len counts beats minus one
  typedef struct packed {
    logic [`ICACHE_PADDR_W-1:0] addr;
    logic [7:0]                 len;
    logic [1:0]                 id;
  } ar_chan_t;

  typedef struct packed {
    logic [63:0] data;
    logic        last;
    logic [1:0]  resp;
    logic [1:0]  id;
  } r_chan_t;

endpackage

`default_nettype wire

// ==== design/icache_subsys.sv ====
/* Instruction-fetch cache with an AXI-style read port. One miss or bypass is in flight at a
   time, and the R channel has no back-pressure. */
`timescale 1ns/100ps
`default_nettype none

module icache_subsys import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fetch_req_t fetch_req_i,
  output logic       fetch_ready_o,
  output fetch_rsp_t fetch_rsp_o,
  input  logic       en_i,
  input  logic       flush_i,
  output logic       miss_o,
  output ar_chan_t   ar_o,
  output logic       ar_valid_o,
  input  logic       ar_ready_i,
  input  r_chan_t    r_i,
  input  logic       r_valid_i
);

  logic        lookup;
  fetch_addr_u lookup_addr;
  logic        hit;
  logic [63:0] hit_data;
  logic        miss_req;
  miss_req_t   miss;
  logic        refill_valid;
  refill_t     refill;
  logic        rd_req;
  logic        rd_gnt;
  ar_chan_t    ar_req;
  logic        beat_valid;
  logic [63:0] beat_data;
  logic        beat_last;
  logic        beat_err;

  fetch_ctrl i_fetch_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_req_i    (fetch_req_i),
    .en_i           (en_i),
    .flush_i        (flush_i),
    .hit_i          (hit),
    .hit_data_i     (hit_data),
    .refill_valid_i (refill_valid),
    .refill_i       (refill),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_rsp_o    (fetch_rsp_o),
    .lookup_o       (lookup),
    .lookup_addr_o  (lookup_addr),
    .miss_req_o     (miss_req),
    .miss_o         (miss),
    .miss_pulse_o   (miss_o)
  );

  icache_array i_icache_array (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lookup_i       (lookup),
    .lookup_addr_i  (lookup_addr),
    .flush_i        (flush_i),
    .refill_valid_i (refill_valid),
    .refill_i       (refill),
    .hit_o          (hit),
    .hit_data_o     (hit_data)
  );

  refill_adapter i_refill_adapter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .miss_req_i     (miss_req),
    .miss_i         (miss),
    .rd_gnt_i       (rd_gnt),
    .beat_valid_i   (beat_valid),
    .beat_data_i    (beat_data),
    .beat_last_i    (beat_last),
    .beat_err_i     (beat_err),
    .rd_req_o       (rd_req),
    .ar_o           (ar_req),
    .refill_valid_o (refill_valid),
    .refill_o       (refill)
  );

  axi_read_shim i_axi_read_shim (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_req_i     (rd_req),
    .ar_i         (ar_req),
    .ar_ready_i   (ar_ready_i),
    .r_i          (r_i),
    .r_valid_i    (r_valid_i),
    .rd_gnt_o     (rd_gnt),
    .ar_o         (ar_o),
    .ar_valid_o   (ar_valid_o),
    .beat_valid_o (beat_valid),
    .beat_data_o  (beat_data),
    .beat_last_o  (beat_last),
    .beat_err_o   (beat_err)
  );

endmodule

`default_nettype wire

// ==== design/refill_adapter.sv ====
/* Turns a miss strobe into a held bus request and packs the returning beats into a line.
   The miss is taken in the cycle it is raised, and only one may be outstanding. */
`timescale 1ns/100ps
`default_nettype none

`include "icache_cfg.svh"

module refill_adapter import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        miss_req_i,
  input  miss_req_t   miss_i,
  input  logic        rd_gnt_i,
  input  logic        beat_valid_i,
  input  logic [63:0] beat_data_i,
  input  logic        beat_last_i,
  input  logic        beat_err_i,
  output logic        rd_req_o,
  output ar_chan_t    ar_o,
  output logic        refill_valid_o,
  output refill_t     refill_o
);

  logic      req_valid_d, req_valid_q;
  miss_req_t req_d, req_q;
  logic      first_d, first_q;
  line_t     shift_d, shift_q;

  // Hold the request until the shim grants the address phase
  assign req_valid_d = ~rd_gnt_i & (miss_req_i | req_valid_q);
  assign req_d       = miss_req_i ? miss_i : req_q;
  assign rd_req_o    = miss_req_i | req_valid_q;

  // Whole line on a fill, single word on a bypass
  assign ar_o = '{
    addr: req_d.paddr,
    len:  req_d.nc ? 8'd0 : 8'(`ICACHE_LINE_WORDS - 1),
    id:   req_d.tid
  };

  // Beats enter from the top so the first one ends up at offset 0
  always_comb begin
    first_d = first_q;
    shift_d = shift_q;
    if (beat_valid_i) begin
      first_d = beat_last_i;
      shift_d = {beat_data_i, shift_q[`ICACHE_LINE_WORDS-1:1]};
      // A one-beat transfer would otherwise land at the top word
      if (first_q) begin
        shift_d[0] = beat_data_i;
      end
    end
  end

  // Line leaves in the cycle of the last beat
  assign refill_valid_o = beat_valid_i & beat_last_i;
  assign refill_o       = '{data: shift_d, err: beat_err_i, tid: req_q.tid};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
      first_q     <= 1'b1;
    end else begin
      req_valid_q <= req_valid_d;
      first_q     <= first_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_q   <= req_d;
    shift_q <= shift_d;
  end

  a_no_miss_while_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_req_i |-> !req_valid_q);

endmodule

`default_nettype wire

// ==== include/icache_cfg.svh ====
/* Cache geometry used at build time. Line words and set count are powers of two, and a line
   holds at least 2 words. The uncached base has to fit in ICACHE_PADDR_W bits. */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// 64-bit words per cache line
`define ICACHE_LINE_WORDS 4

// Number of sets in the direct-mapped array
`define ICACHE_SETS 16

// Physical address width
`define ICACHE_PADDR_W 32

// Fetches at or above this address bypass the cache
`define ICACHE_UNCACHED_BASE 32'h8000_0000

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Builds the fetch cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_icache \
  -f src.f -o tb_icache_sim \
  && ./obj_dir/tb_icache_sim > sim.log 2>&1 \
  || echo "Build or simulation reported an error"
cat sim.log 2>/dev/null
grep -qx '>>> PASS' sim.log 2>/dev/null && echo "Result: pass" && exit 0 \
  || { echo "Result: fail"; exit 1; }

// ==== src.f ====
+incdir+include
design/icache_pkg.sv
design/fetch_ctrl.sv
design/icache_array.sv
design/refill_adapter.sv
design/axi_read_shim.sv
design/icache_subsys.sv
test/tb_icache.sv

// ==== test/tb_icache.sv ====
/* Directed tests for the fetch cache against a behavioral AXI-style read memory.
   Memory data is the beat address XOR a key, and one address window answers with SLVERR. */
`timescale 1ns/100ps
`default_nettype none

`include "icache_cfg.svh"

module tb_icache import icache_pkg::*; ();

  localparam int          WAIT_LIMIT = 100;
  localparam logic [63:0] DATA_KEY   = 64'hC0DE_5EED_0BAD_F00D;
  localparam logic [31:0] LINE_A     = 32'h0000_1040;
  localparam logic [31:0] ERR_LO     = 32'h0000_4000;
  localparam logic [31:0] ERR_HI     = 32'h0000_40FF;

  logic       clk_i;
  logic       rst_ni;
  fetch_req_t fetch_req_i;
  logic       fetch_ready_o;
  fetch_rsp_t fetch_rsp_o;
  logic       en_i;
  logic       flush_i;
  logic       miss_o;
  ar_chan_t   ar_o;
  logic       ar_valid_o;
  logic       ar_ready_i;
  r_chan_t    r_i;
  logic       r_valid_i;

  // Memory model bookkeeping
  logic       stall_ar;
  ar_chan_t   last_ar;
  int         ar_cnt;

  icache_subsys dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_req_i   (fetch_req_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_rsp_o   (fetch_rsp_o),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .miss_o        (miss_o),
    .ar_o          (ar_o),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .r_i           (r_i),
    .r_valid_i     (r_valid_i)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [63:0] model_word(input logic [31:0] addr);
    return {32'h0, addr} ^ DATA_KEY;
  endfunction

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ERR_LO) && (addr <= ERR_HI);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("FAILED at %0d ns: %s, expected %h, got %h",
                          $time, what, exp, act));
    end
  endtask

  // Answers one AR at a time, with 0 to 3 idle cycles before the first beat
  initial begin : bus_memory
    int unsigned gap;
    ar_chan_t    ar;
    logic [31:0] beat_addr;
    void'($urandom(32'h9268));
    r_i        = '0;
    r_valid_i  = 1'b0;
    ar_ready_i = 1'b1;
    last_ar    = '0;
    ar_cnt     = 0;
    forever begin
      @(negedge clk_i);
      r_valid_i  = 1'b0;
      ar_ready_i = ~stall_ar;
      if (ar_valid_o && ar_ready_i) begin
        ar      = ar_o;
        last_ar = ar;
        ar_cnt++;
        gap = $urandom % 4;
        repeat (gap + 1) @(negedge clk_i);
        for (int b = 0; b <= int'(ar.len); b++) begin
          if (b > 0) begin
            @(negedge clk_i);
          end
          beat_addr = ar.addr + 32'(b) * 32'd8;
          r_i.data  = model_word(beat_addr);
          r_i.last  = (b == int'(ar.len));
          r_i.resp  = in_err_window(beat_addr) ? 2'b10 : 2'b00;
          r_i.id    = ar.id;
          r_valid_i = 1'b1;
        end
      end
    end
  end

  task automatic issue_fetch(input logic [31:0] addr);
    int waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("fetch_ready_o stayed low too long");
      end
    end while (!fetch_ready_o);
    fetch_req_i.req        = 1'b1;
    fetch_req_i.addr.paddr = addr;
  endtask

  // One fetch, counting miss pulses and cycles from acceptance to response
  task automatic fetch_word(input logic [31:0] addr, input logic exp_miss, input logic exp_err);
    int          cycles;
    int          misses;
    logic [31:0] word_addr;
    cycles    = 0;
    misses    = 0;
    word_addr = addr;
    word_addr[2:0] = 3'b000;
    issue_fetch(addr);
    do begin
      @(negedge clk_i);
      fetch_req_i.req = 1'b0;
      cycles++;
      if (miss_o) begin
        misses++;
      end
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("no fetch response for address %h", addr));
      end
    end while (!fetch_rsp_o.valid);
    check_eq(64'(misses), 64'(exp_miss), "miss_o pulses for one fetch");
    if (!exp_miss) begin
      check_eq(64'(cycles), 64'(1), "hit latency");
    end
    check_eq(fetch_rsp_o.data, model_word(word_addr), "fetch data");
    check_eq(64'(fetch_rsp_o.err), 64'(exp_err), "fetch error bit");
  endtask

  // Keeps AR stalled for a while and checks that the request holds still
  task automatic hold_ar_check(input int hold_cycles);
    ar_chan_t held;
    int       waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("ar_valid_o never rose under back-pressure");
      end
    end while (!ar_valid_o);
    held = ar_o;
    check_eq(64'(held.len), 64'(`ICACHE_LINE_WORDS - 1), "stalled burst length");
    repeat (hold_cycles) begin
      @(negedge clk_i);
      check_eq(64'(ar_valid_o), 64'(1), "ar_valid_o held under back-pressure");
      check_eq(64'(ar_o), 64'(held), "ar_o held under back-pressure");
    end
    stall_ar = 1'b0;
  endtask

  task automatic pulse_flush();
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    check_eq(64'(fetch_ready_o), 64'(0), "fetch_ready_o during flush");
    flush_i = 1'b0;
  endtask

  task automatic check_reset_state();
    @(negedge clk_i);
    check_eq(64'(fetch_ready_o), 64'(1), "fetch_ready_o after reset");
    check_eq(64'(fetch_rsp_o.valid), 64'(0), "response valid after reset");
    check_eq(64'(miss_o), 64'(0), "miss_o after reset");
    check_eq(64'(ar_valid_o), 64'(0), "ar_valid_o after reset");
  endtask

  task automatic test_cold_miss();
    int ar_before;
    ar_before = ar_cnt;
    fetch_word(LINE_A + 32'd8, 1'b1, 1'b0);
    check_eq(64'(last_ar.len), 64'(`ICACHE_LINE_WORDS - 1), "cold miss burst length");
    check_eq(64'(last_ar.addr), 64'(LINE_A), "cold miss line address");
    // Byte offset inside each word must not matter
    for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
      fetch_word(LINE_A + 32'(w) * 32'd8 + 32'd4, 1'b0, 1'b0);
    end
    check_eq(64'(ar_cnt - ar_before), 64'(1), "bus requests for one line");
  endtask

  task automatic test_uncached();
    logic [31:0] addr;
    addr = `ICACHE_UNCACHED_BASE + 32'h0000_246C;
    fetch_word(addr, 1'b1, 1'b0);
    check_eq(64'(last_ar.len), 64'(0), "uncached burst length");
    check_eq(64'(last_ar.addr), 64'(addr & ~32'h7), "uncached word address");
    fetch_word(addr, 1'b1, 1'b0);
  endtask

  task automatic test_flush();
    fetch_word(LINE_A, 1'b0, 1'b0);
    pulse_flush();
    fetch_word(LINE_A, 1'b1, 1'b0);
    fetch_word(LINE_A + 32'd16, 1'b0, 1'b0);
  endtask

  task automatic test_disable();
    en_i = 1'b0;
    fetch_word(LINE_A + 32'd24, 1'b1, 1'b0);
    check_eq(64'(last_ar.len), 64'(0), "disabled fetch burst length");
    check_eq(64'(last_ar.addr), 64'(LINE_A + 32'd24), "disabled fetch address");
    en_i = 1'b1;
    // Line stays resident across the bypass
    fetch_word(LINE_A + 32'd24, 1'b0, 1'b0);
  endtask

  task automatic test_backpressure_error();
    stall_ar = 1'b1;
    fork
      fetch_word(ERR_LO + 32'h10, 1'b1, 1'b1);
      hold_ar_check(5);
    join
    fetch_word(ERR_LO + 32'h10, 1'b1, 1'b1);
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    fetch_req_i = '0;
    en_i        = 1'b1;
    flush_i     = 1'b0;
    stall_ar    = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_reset_state();
    test_cold_miss();
    test_uncached();
    test_flush();
    test_disable();
    test_backpressure_error();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
